//--- verif/aes_key_stimulus.txt
# Block header: direction (fwd or inv), key length in bits, 256-bit load key
# Then one round key per line in output order, all in FIPS-197 byte order
fwd 128 2b7e151628aed2a6abf7158809cf4f3c00000000000000000000000000000000
2b7e151628aed2a6abf7158809cf4f3c
a0fafe1788542cb123a339392a6c7605
f2c295f27a96b9435935807a7359f67f
3d80477d4716fe3e1e237e446d7a883b
ef44a541a8525b7fb671253bdb0bad00
d4d1c6f87c839d87caf2b8bc11f915bc
6d88a37a110b3efddbf98641ca0093fd
4e54f70e5f5fc9f384a64fb24ea6dc4f
ead27321b58dbad2312bf5607f8d292f
ac7766f319fadc2128d12941575c006e
d014f9a8c9ee2589e13f0cc8b6630ca6
inv 128 d014f9a8c9ee2589e13f0cc8b6630ca600000000000000000000000000000000
d014f9a8c9ee2589e13f0cc8b6630ca6
ac7766f319fadc2128d12941575c006e
ead27321b58dbad2312bf5607f8d292f
4e54f70e5f5fc9f384a64fb24ea6dc4f
6d88a37a110b3efddbf98641ca0093fd
d4d1c6f87c839d87caf2b8bc11f915bc
ef44a541a8525b7fb671253bdb0bad00
3d80477d4716fe3e1e237e446d7a883b
f2c295f27a96b9435935807a7359f67f
a0fafe1788542cb123a339392a6c7605
2b7e151628aed2a6abf7158809cf4f3c
fwd 256 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4
603deb1015ca71be2b73aef0857d7781
1f352c073b6108d72d9810a30914dff4
9ba354118e6925afa51a8b5f2067fcde
a8b09c1a93d194cdbe49846eb75d5b9a
d59aecb85bf3c917fee94248de8ebe96
b5a9328a2678a647983122292f6c79b3
812c81addadf48ba24360af2fab8b464
98c5bfc9bebd198e268c3ba709e04214
68007bacb2df331696e939e46c518d80
c814e20476a9fb8a5025c02d59c58239
de1369676ccc5a71fa2563959674ee15
5886ca5d2e2f31d77e0af1fa27cf73c3
749c47ab18501ddae2757e4f7401905a
cafaaae3e4d59b349adf6acebd10190d
fe4890d1e6188d0b046df344706c631e
inv 256 cafaaae3e4d59b349adf6acebd10190dfe4890d1e6188d0b046df344706c631e
fe4890d1e6188d0b046df344706c631e
cafaaae3e4d59b349adf6acebd10190d
749c47ab18501ddae2757e4f7401905a
5886ca5d2e2f31d77e0af1fa27cf73c3
de1369676ccc5a71fa2563959674ee15
c814e20476a9fb8a5025c02d59c58239
68007bacb2df331696e939e46c518d80
98c5bfc9bebd198e268c3ba709e04214
812c81addadf48ba24360af2fab8b464
b5a9328a2678a647983122292f6c79b3
d59aecb85bf3c917fee94248de8ebe96
a8b09c1a93d194cdbe49846eb75d5b9a
9ba354118e6925afa51a8b5f2067fcde
1f352c073b6108d72d9810a30914dff4
603deb1015ca71be2b73aef0857d7781

//--- files.f
+incdir+include
source/aes_key_pkg.sv
source/aes_sbox_lut.sv
source/aes_sub_word.sv
source/aes_key_expand.sv
source/aes_key_state.sv
source/aes_key_sched_top.sv
verif/tb_aes_key_sched.sv

//--- run.sh
#!/bin/sh
# Build and run the key schedule testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_aes_key_sched

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0

//--- verif/tb_aes_key_sched.sv
////////////////////////////////////////////////////////////
// Testbench for the AES key schedule
// Stimulus file lists FIPS-197 words in FIPS byte order
// Run from the project root so the data file is found
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aes_key_cfg.svh"

module tb_aes_key_sched import aes_key_pkg::*; ();

  localparam int NUM_BLOCKS   = 4;
  localparam int NUM_KEYS     = `AES_ROUNDS_256 + 1;
  localparam int RESET_CYCLES = 16;
  // Reset plus five runs of up to 15 steps is about 100 cycles
  localparam int MAX_CYCLES   = 400;

  logic         clk_i;
  logic         rst_ni;
  logic         load_i;
  logic         step_i;
  logic [255:0] key_i;
  ciph_op_e     op_i;
  key_len_e     key_len_i;
  logic [127:0] round_key_o;
  logic   [3:0] round_o;
  logic         key_valid_o;
  logic         done_o;

  // Blocks from the data file, already in DUT byte order
  logic [255:0] load_keys [NUM_BLOCKS];
  logic [127:0] exp_keys  [NUM_BLOCKS][NUM_KEYS];
  bit           blk_inv   [NUM_BLOCKS];
  bit           blk_256   [NUM_BLOCKS];
  int           blk_last  [NUM_BLOCKS];
  int           cycle_count = 0;

  aes_key_sched_top uut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .load_i      ( load_i      ),
    .step_i      ( step_i      ),
    .key_i       ( key_i       ),
    .op_i        ( op_i        ),
    .key_len_i   ( key_len_i   ),
    .round_key_o ( round_key_o ),
    .round_o     ( round_o     ),
    .key_valid_o ( key_valid_o ),
    .done_o      ( done_o      )
  );

  // 8 ns clock
  initial begin : clock_gen
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("error: time %0t signal %s got %h expected %h", $time, name, got, exp);
      stop_with_failure("value mismatch");
    end
  endtask

  // FIPS text puts byte 0 first while the DUT keeps it in the low bits
  function automatic logic [255:0] swap_bytes(input logic [255:0] v, input int nbytes);
    logic [255:0] r;
    r = '0;
    for (int i = 0; i < nbytes; i++) begin
      r[8*i +: 8] = v[8*(nbytes-1-i) +: 8];
    end
    return r;
  endfunction

  // Next line that is neither blank nor a comment
  task automatic read_data_line(input int fd, output string line);
    int code;
    do begin
      line = "";
      code = $fgets(line, fd);
      if (code == 0) begin
        $display("error: stimulus file ended before all blocks were read");
        stop_with_failure("stimulus file too short");
      end
    end while (line.len() < 2 || line.getc(0) == "#");
  endtask

  task automatic read_stimulus();
    int           fd;
    int           count;
    int           key_bits;
    string        line;
    logic  [23:0] dir;
    logic [255:0] value;
    fd = $fopen("verif/aes_key_stimulus.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open verif/aes_key_stimulus.txt");
      stop_with_failure("stimulus file missing");
    end
    for (int b = 0; b < NUM_BLOCKS; b++) begin
      // Block header with direction, key length and load key
      read_data_line(fd, line);
      count = $sscanf(line, "%s %d %h", dir, key_bits, value);
      if (count != 3) begin
        $display("error: bad block header in stimulus file: %s", line);
        stop_with_failure("bad stimulus header");
      end
      blk_inv[b]   = (dir == "inv");
      blk_256[b]   = (key_bits == 256);
      blk_last[b]  = blk_256[b] ? `AES_ROUNDS_256 : `AES_ROUNDS_128;
      load_keys[b] = swap_bytes(value, 32);
      // Expected round keys in output order
      for (int r = 0; r <= blk_last[b]; r++) begin
        read_data_line(fd, line);
        count = $sscanf(line, "%h", value);
        if (count != 1) begin
          $display("error: bad round key line in stimulus file: %s", line);
          stop_with_failure("bad stimulus round key");
        end
        value = swap_bytes(value, 16);
        exp_keys[b][r] = value[127:0];
      end
    end
    $fclose(fd);
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_round(input int b, input int r);
    check_value("round_key_o", round_key_o, exp_keys[b][r]);
    check_value("round_o", 128'(round_o), 128'(r));
    check_value("key_valid_o", 128'(key_valid_o), 128'(1));
    check_value("done_o", 128'(done_o), 128'(r == blk_last[b]));
  endtask

  // Round key 0 is due one cycle after the load
  task automatic load_block(input int b, input bit with_step);
    key_i     = load_keys[b];
    op_i      = blk_inv[b] ? CIPH_INV : CIPH_FWD;
    key_len_i = blk_256[b] ? AES_256 : AES_128;
    load_i    = 1'b1;
    step_i    = with_step;
    next_cycle();
    load_i    = 1'b0;
    step_i    = 1'b0;
    check_round(b, 0);
  endtask

  task automatic step_once();
    step_i = 1'b1;
    next_cycle();
    step_i = 1'b0;
  endtask

  task automatic run_rounds(input int b, input int first, input int last);
    for (int r = first; r <= last; r++) begin
      step_once();
      check_round(b, r);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : watchdog
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("error: simulation did not finish within %0d cycles", MAX_CYCLES);
      stop_with_failure("timeout");
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    rst_ni    = 1'b0;
    load_i    = 1'b0;
    step_i    = 1'b0;
    key_i     = '0;
    op_i      = CIPH_FWD;
    key_len_i = AES_128;
    read_stimulus();

    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Idle after reset with the key state cleared
    check_value("key_valid_o", 128'(key_valid_o), 128'(0));
    check_value("done_o", 128'(done_o), 128'(0));
    check_value("round_o", 128'(round_o), 128'(0));
    check_value("round_key_o", round_key_o, 128'(0));

    // No load yet so a step does nothing
    step_once();
    check_value("round_o", 128'(round_o), 128'(0));
    check_value("key_valid_o", 128'(key_valid_o), 128'(0));

    // Full runs with one extra step at the last round of each
    for (int b = 0; b < NUM_BLOCKS; b++) begin
      load_block(b, 1'b0);
      run_rounds(b, 1, blk_last[b]);
      step_once();
      check_round(b, blk_last[b]);
    end

    // Restart mid-run with load and step high together
    load_block(0, 1'b0);
    run_rounds(0, 1, 4);
    load_block(3, 1'b1);
    run_rounds(3, 1, blk_last[3]);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/aes_key_sched_top.sv
////////////////////////////////////////////////////////////
// AES-128/256 key schedule with one round per step pulse
// Inverse runs load the final full-key state of a forward run
// Round key 0 appears one cycle after load_i
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aes_key_cfg.svh"

module aes_key_sched_top import aes_key_pkg::*; (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       load_i,
  input  logic                                       step_i,
  input  logic [`AES_KEY_WORDS*`AES_WORD_W-1:0]      key_i,
  input  ciph_op_e                                   op_i,
  input  key_len_e                                   key_len_i,
  output logic [4*`AES_WORD_W-1:0]                   round_key_o,
  output logic                                 [3:0] round_o,
  output logic                                       key_valid_o,
  output logic                                       done_o
);

  logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] key_q;
  logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] key_next;
  ciph_op_e                                   op_q;
  key_len_e                                   key_len_q;
  logic                                 [3:0] round_q;
  logic                                 [7:0] rcon_q;
  logic                                       use_rcon;

  // Registers and output select
  aes_key_state u_state (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .load_i      ( load_i      ),
    .step_i      ( step_i      ),
    .key_i       ( key_i       ),
    .op_i        ( op_i        ),
    .key_len_i   ( key_len_i   ),
    .key_next_i  ( key_next    ),
    .use_rcon_i  ( use_rcon    ),
    .key_o       ( key_q       ),
    .op_o        ( op_q        ),
    .key_len_o   ( key_len_q   ),
    .round_o     ( round_q     ),
    .rcon_o      ( rcon_q      ),
    .round_key_o ( round_key_o ),
    .key_valid_o ( key_valid_o ),
    .done_o      ( done_o      )
  );

  // Combinational round update
  aes_key_expand u_expand (
    .key_i      ( key_q     ),
    .op_i       ( op_q      ),
    .key_len_i  ( key_len_q ),
    .round_i    ( round_q   ),
    .rcon_i     ( rcon_q    ),
    .key_next_o ( key_next  ),
    .use_rcon_o ( use_rcon  )
  );

  assign round_o = round_q;

endmodule

`default_nettype wire

//--- source/aes_key_state.sv
////////////////////////////////////////////////////////////
// Key state, configuration, Rcon and round counter
// load_i wins over step_i in the same cycle
// Steps before the first load or at the last round are ignored
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aes_key_cfg.svh"

module aes_key_state import aes_key_pkg::*; (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       load_i,
  input  logic                                       step_i,
  input  logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] key_i,
  input  ciph_op_e                                   op_i,
  input  key_len_e                                   key_len_i,
  input  logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] key_next_i,
  input  logic                                       use_rcon_i,
  output logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] key_o,
  output ciph_op_e                                   op_o,
  output key_len_e                                   key_len_o,
  output logic                                 [3:0] round_o,
  output logic                                 [7:0] rcon_o,
  output logic                   [4*`AES_WORD_W-1:0] round_key_o,
  output logic                                       key_valid_o,
  output logic                                       done_o
);

  logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] key_q;
  ciph_op_e                                   op_q;
  key_len_e                                   key_len_q;
  logic                                 [3:0] round_q;
  logic                                 [7:0] rcon_q;
  logic                                 [7:0] rcon_init;
  logic                                 [3:0] last_round;
  logic                                       valid_q;
  logic                                       step_en;
  logic                                       key_we;
  logic                                       sel_upper;

  // Last round index for the stored length
  assign last_round = (key_len_q == AES_256) ? 4'(`AES_ROUNDS_256) : 4'(`AES_ROUNDS_128);

  assign done_o  = valid_q && (round_q == last_round);
  assign step_en = step_i && !load_i && valid_q && !done_o;

  // AES-256 round 0 advances the counter only
  assign key_we = step_en && ((key_len_q == AES_128) || (round_q != 4'd0));

  // Rcon start value
  always_comb begin : rcon_start
    if (op_i == CIPH_INV) begin
      rcon_init = (key_len_i == AES_256) ? `AES_RCON_INV_256 : `AES_RCON_INV_128;
    end else begin
      rcon_init = `AES_RCON_FWD;
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  // Configuration
  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_cfg
    if (!rst_ni) begin
      op_q      <= CIPH_FWD;
      key_len_q <= AES_128;
      valid_q   <= 1'b0;
    end else if (load_i) begin
      op_q      <= op_i;
      key_len_q <= key_len_i;
      valid_q   <= 1'b1;
    end
  end

  // Full-key state
  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_key
    if (!rst_ni) begin
      key_q <= '0;
    end else if (load_i) begin
      key_q <= key_i;
    end else if (key_we) begin
      key_q <= key_next_i;
    end
  end

  // Rcon moves only on rounds that consumed it
  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_rcon
    if (!rst_ni) begin
      rcon_q <= '0;
    end else if (load_i) begin
      rcon_q <= rcon_init;
    end else if (step_en && use_rcon_i) begin
      rcon_q <= (op_q == CIPH_FWD) ? aes_mul2(rcon_q) : aes_div2(rcon_q);
    end
  end

  // Round counter
  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_round
    if (!rst_ni) begin
      round_q <= 4'd0;
    end else if (load_i) begin
      round_q <= 4'd0;
    end else if (step_en) begin
      round_q <= round_q + 4'd1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Upper half for AES-256 forward after round 0 and inverse at round 0
  always_comb begin : half_select
    if (key_len_q == AES_256) begin
      sel_upper = (op_q == CIPH_INV) ? (round_q == 4'd0) : (round_q != 4'd0);
    end else begin
      sel_upper = 1'b0;
    end
  end

  assign round_key_o = sel_upper ? key_q[7:4] : key_q[3:0];
  assign key_o       = key_q;
  assign op_o        = op_q;
  assign key_len_o   = key_len_q;
  assign round_o     = round_q;
  assign rcon_o      = rcon_q;
  assign key_valid_o = valid_q;

  // Configuration from outside must be a defined code
  a_load_cfg_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_i |-> (op_i inside {CIPH_FWD, CIPH_INV}) && (key_len_i inside {AES_128, AES_256}));

  // Counter stays within the schedule of the stored length
  a_round_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    round_q <= last_round);

endmodule

`default_nettype wire

//--- source/aes_key_expand.sv
////////////////////////////////////////////////////////////
// Next full-key state for one round, both directions
// AES-128 uses words 3..0 only and leaves 7..4 as they are
// AES-256 round 0 is handled by the register block
// Zero latency, no clock
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aes_key_cfg.svh"

module aes_key_expand import aes_key_pkg::*; (
  input  logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] key_i,
  input  ciph_op_e                                   op_i,
  input  key_len_e                                   key_len_i,
  input  logic                                 [3:0] round_i,
  input  logic                                 [7:0] rcon_i,
  output logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] key_next_o,
  output logic                                       use_rcon_o
);

  logic                                       use_rot_word;
  logic                     [`AES_WORD_W-1:0] rot_word_in;
  logic                     [`AES_WORD_W-1:0] irregular;
  logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] regular;

  ////////////////////////////////////////////////////////////
  // Irregular part
  ////////////////////////////////////////////////////////////

  // Even AES-256 rounds use plain SubWord
  assign use_rot_word = !((key_len_i == AES_256) && !round_i[0]);

  // Rcon goes with RotWord in every case
  assign use_rcon_o = use_rot_word;

  // RotWord source word
  always_comb begin : rot_word_in_mux
    if (key_len_i == AES_256) begin
      // Inverse reads the old lower half
      rot_word_in = (op_i == CIPH_INV) ? key_i[3] : key_i[7];
    end else begin
      // Inverse needs the previous word 3 which equals 3 XOR 2
      rot_word_in = (op_i == CIPH_INV) ? (key_i[3] ^ key_i[2]) : key_i[3];
    end
  end

  aes_sub_word u_sub_word (
    .word_i     ( rot_word_in  ),
    .use_rot_i  ( use_rot_word ),
    .rcon_i     ( rcon_i       ),
    .use_rcon_i ( use_rcon_o   ),
    .word_o     ( irregular    )
  );

  ////////////////////////////////////////////////////////////
  // Regular part
  ////////////////////////////////////////////////////////////

  always_comb begin : drive_regular
    // Unused words keep their value
    regular = key_i;

    if (key_len_i == AES_256) begin
      if (op_i == CIPH_INV) begin
        // Old lower half moves up
        regular[7:4] = key_i[3:0];
        // New lower half
        regular[0] = irregular ^ key_i[4];
        for (int i = 0; i < 3; i++) begin
          regular[i+1] = key_i[4+i] ^ key_i[4+i+1];
        end
      end else begin
        // Old upper half moves down
        regular[3:0] = key_i[7:4];
        // New upper half as an XOR chain
        regular[4] = irregular ^ key_i[0];
        for (int i = 1; i < 4; i++) begin
          regular[i+4] = regular[i+3] ^ key_i[i];
        end
      end
    end else begin
      regular[0] = irregular ^ key_i[0];
      if (op_i == CIPH_INV) begin
        // Undo the chain using neighbouring words
        for (int i = 1; i < 4; i++) begin
          regular[i] = key_i[i-1] ^ key_i[i];
        end
      end else begin
        for (int i = 1; i < 4; i++) begin
          regular[i] = regular[i-1] ^ key_i[i];
        end
      end
    end
  end

  assign key_next_o = regular;

endmodule

`default_nettype wire

//--- source/aes_sub_word.sv
////////////////////////////////////////////////////////////
// Irregular word of the key schedule
// Byte 0 sits in bits 7:0 and is the first byte in FIPS order
// Fully combinational with four forward S-boxes
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "aes_key_cfg.svh"

module aes_sub_word (
  input  logic [`AES_WORD_W-1:0] word_i,
  input  logic                   use_rot_i,
  input  logic             [7:0] rcon_i,
  input  logic                   use_rcon_i,
  output logic [`AES_WORD_W-1:0] word_o
);

  logic [`AES_WORD_W-1:0] rot_word;
  logic [`AES_WORD_W-1:0] sub_in;
  logic [`AES_WORD_W-1:0] sub_out;
  logic             [7:0] rcon_add;

  // RotWord moves byte 0 to the top
  // so byte 1 becomes the new first byte
  assign rot_word = {word_i[7:0], word_i[`AES_WORD_W-1:8]};

  // Even AES-256 rounds skip the rotation
  assign sub_in = use_rot_i ? rot_word : word_i;

  ////////////////////////////////////////////////////////////
  // SubWord
  ////////////////////////////////////////////////////////////

  for (genvar b = 0; b < `AES_WORD_W / 8; b++) begin : gen_sbox
    aes_sbox_lut u_sbox (
      .data_i ( sub_in[8*b +: 8]  ),
      .data_o ( sub_out[8*b +: 8] )
    );
  end

  // Rcon only touches the first byte
  assign rcon_add = use_rcon_i ? rcon_i : 8'h00;

  assign word_o = {sub_out[`AES_WORD_W-1:8], sub_out[7:0] ^ rcon_add};

endmodule

`default_nettype wire

//--- source/aes_sbox_lut.sv
////////////////////////////////////////////////////////////
// Forward AES S-box for one byte
// Pure table lookup with no clock and no inverse path
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module aes_sbox_lut (
  input  logic [7:0] data_i,
  output logic [7:0] data_o
);

  // Substitution table from FIPS-197 indexed by the input byte
  localparam logic [7:0] SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Lookup
  assign data_o = SBOX[data_i];

endmodule

`default_nettype wire

//--- source/aes_key_pkg.sv
////////////////////////////////////////////////////////////
// Types and GF(2^8) helpers for the key schedule
// Enums are 2 bits wide so undefined codes stay visible
////////////////////////////////////////////////////////////

`default_nettype none

package aes_key_pkg;

  // Direction of the expansion
  typedef enum logic [1:0] {
    CIPH_FWD = 2'b01,
    CIPH_INV = 2'b10
  } ciph_op_e;

  // Supported key lengths
  typedef enum logic [1:0] {
    AES_128 = 2'b01,
    AES_256 = 2'b10
  } key_len_e;

  // Multiply by x modulo 0x11b
  function automatic logic [7:0] aes_mul2(logic [7:0] in);
    logic [7:0] out;
    out = {in[6:0], 1'b0} ^ (in[7] ? 8'h1b : 8'h00);
    return out;
  endfunction

  // Divide by x
  // 0x8d is 0x11b shifted right by one
  function automatic logic [7:0] aes_div2(logic [7:0] in);
    logic [7:0] out;
    out = {1'b0, in[7:1]} ^ (in[0] ? 8'h8d : 8'h00);
    return out;
  endfunction

endpackage

`default_nettype wire

//--- include/aes_key_cfg.svh
////////////////////////////////////////////////////////////
// Fixed AES constants for the key schedule
// Only AES-128 and AES-256 are supported
// Round counts are last round indices and fit in 4 bits
////////////////////////////////////////////////////////////

`ifndef AES_KEY_CFG_SVH
`define AES_KEY_CFG_SVH

// Width of one key word
`define AES_WORD_W 32

// Words held in the full-key state
`define AES_KEY_WORDS 8

// Last round index per key length
`define AES_ROUNDS_128 10
`define AES_ROUNDS_256 14

// Rcon start values
`define AES_RCON_FWD     8'h01
`define AES_RCON_INV_128 8'h36
`define AES_RCON_INV_256 8'h40

`endif
